// ==== build.f ====
+incdir+verilog
verilog/rv_exec_pkg.sv
verilog/forward_unit.sv
verilog/alu.sv
verilog/branch_resolve.sv
verilog/ex_stage.sv
verilog/mem_wb_stage.sv
verilog/exec_pipe_top.sv
bench/exec_pipe_properties.sv
bench/exec_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module exec_pipe_tb -o exec_pipe_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/exec_pipe_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== bench/exec_pipe_tb.sv ====
`timescale 1ns/100ps

`include "rv_exec_consts.svh"

module exec_pipe_tb
    import rv_exec_pkg::*;
;

    typedef struct packed {
        id_ex_t      ins;
        logic [3:0]  stall;
        branch_res_t br;
        wb_t         wb;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        mem_stall;
    logic        dmem_init_en;
    logic [5:0]  dmem_init_addr;
    logic [31:0] dmem_init_data;
    id_ex_t      id_ex;
    branch_res_t branch_res;
    wb_t         wb;

    logic [31:0] lfsr_state;
    logic [31:0] regs_model [32];
    logic [31:0] mem_model [64];
    logic [5:0]  pend1;
    logic [5:0]  pend2;
    logic [31:0] pc_next;
    row_t        rows [$];
    wb_t         ex_exp;
    wb_t         wb_exp;

    exec_pipe_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_ex          (id_ex),
        .mem_stall      (mem_stall),
        .dmem_init_en   (dmem_init_en),
        .dmem_init_addr (dmem_init_addr),
        .dmem_init_data (dmem_init_data),
        .branch_res     (branch_res),
        .wb             (wb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // galois lfsr stepped once per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'hA300_0001;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand32();
        logic [31:0] v;
        for (int i = 0; i < 32; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [5:0] addr);
        return 32'hC3A5_0000 ^ {addr, 26'd0} ^ {20'd0, addr, 6'd0} ^ {26'd0, addr};
    endfunction

    // reference results straight from the instruction set rules
    function automatic logic [31:0] expect_alu(input logic [3:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] shifted;
        sa = a;
        shifted = sa >>> b[4:0];
        case (op)
            `ALU_ADD: return a + b;
            `ALU_SUB: return a - b;
            `ALU_AND: return a & b;
            `ALU_OR:  return a | b;
            `ALU_XOR: return a ^ b;
            `ALU_SLL: return a << b[4:0];
            `ALU_SRL: return a >> b[4:0];
            `ALU_SRA: return shifted;
            `ALU_SLT: return (sa < $signed(b)) ? 32'd1 : 32'd0;
            default:  return 32'd0;
        endcase
    endfunction

    // a register still in flight is handed over stale from the register file
    function automatic logic is_pending(input logic [4:0] rs);
        return rs != 5'd0 && ({1'b0, rs} == pend1 || {1'b0, rs} == pend2);
    endfunction

    function automatic id_ex_t make_ins(input logic [3:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [31:0] imm, input logic src_imm);
        id_ex_t ins;
        ins = '0;
        ins.valid = 1'b1;
        ins.pc = pc_next;
        ins.alu_op = op;
        ins.rd = rd;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.imm = imm;
        ins.alu_src_imm = src_imm;
        ins.reg_write = 1'b1;
        return ins;
    endfunction

    task automatic add_row(input id_ex_t ins, input logic [3:0] stall);
        row_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = regs_model[ins.rs1];
        b = regs_model[ins.rs2];
        ins.rs1_data = is_pending(ins.rs1) ? rand32() : a;
        ins.rs2_data = is_pending(ins.rs2) ? rand32() : b;
        res = expect_alu(ins.alu_op, a, ins.alu_src_imm ? ins.imm : b);
        r.br = '0;
        r.br.pc = ins.pc;
        r.br.is_branch = ins.is_branch;
        if (ins.is_branch) begin
            case (ins.br_type)
                `BR_JAL: begin
                    r.br.taken = 1'b1;
                    r.br.target = ins.pc + ins.imm;
                end
                `BR_JALR: begin
                    r.br.taken = 1'b1;
                    r.br.target = a + ins.imm;
                end
                default: begin
                    r.br.taken = (ins.br_type == `BR_BEQ) ? (res == 0) : (res != 0);
                    r.br.target = r.br.taken ? ins.pc + ins.imm : ins.pc + 32'd4;
                end
            endcase
            if (ins.br_type == `BR_JAL || ins.br_type == `BR_JALR) begin
                res = ins.pc + 32'd4;
            end
        end
        r.wb.reg_write = ins.valid & ins.reg_write;
        r.wb.rd = ins.rd;
        r.wb.data = ins.mem_read ? mem_model[res[7:2]] : res;
        if (ins.valid && ins.mem_write) begin
            mem_model[res[7:2]] = b;
        end
        if (r.wb.reg_write && ins.rd != 5'd0) begin
            regs_model[ins.rd] = r.wb.data;
        end
        pend2 = pend1;
        pend1 = r.wb.reg_write ? {1'b0, ins.rd} : 6'd32;
        pc_next = pc_next + 32'd4;
        r.ins = ins;
        r.stall = stall;
        rows.push_back(r);
    endtask

    task automatic add_bubble();
        id_ex_t ins;
        // enables stay set and a leaked store would hit the word loaded from 0x84
        ins = make_ins(`ALU_ADD, 5'd31, 5'd0, 5'd0, 32'h84, 1'b1);
        ins.valid = 1'b0;
        ins.mem_write = 1'b1;
        add_row(ins, 4'd0);
    endtask

    task automatic add_branch(input logic [1:0] kind, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [31:0] imm);
        id_ex_t ins;
        ins = make_ins(`ALU_SUB, rd, rs1, rs2, imm, 1'b0);
        ins.is_branch = 1'b1;
        ins.br_type = kind;
        ins.reg_write = (kind == `BR_JAL || kind == `BR_JALR);
        add_row(ins, 4'd0);
    endtask

    task automatic add_mem(input logic is_load, input logic [4:0] reg_n,
                           input logic [31:0] addr, input logic [3:0] stall);
        id_ex_t ins;
        ins = make_ins(`ALU_ADD, is_load ? reg_n : 5'd0, 5'd0, reg_n, addr, 1'b1);
        ins.mem_read = is_load;
        ins.mem_write = !is_load;
        ins.reg_write = is_load;
        add_row(ins, stall);
    endtask

    task automatic build_table();
        add_bubble();
        add_bubble();
        for (int op = 0; op < 9; op++) begin
            add_row(make_ins(4'(op), 5'(10 + op), 5'd1, 5'd2, 32'd0, 1'b0), 4'd0);
            add_row(make_ins(4'(op), 5'(20 + op), 5'd3, 5'd0, rand32(), 1'b1), 4'd0);
        end
        // dependent chains at distance 1 and 2
        add_row(make_ins(`ALU_ADD, 5'd5, 5'd1, 5'd2, 32'd0, 1'b0), 4'd0);
        add_row(make_ins(`ALU_SUB, 5'd6, 5'd5, 5'd3, 32'd0, 1'b0), 4'd0);
        add_row(make_ins(`ALU_XOR, 5'd7, 5'd5, 5'd6, 32'd0, 1'b0), 4'd0);
        add_row(make_ins(`ALU_ADD, 5'd5, 5'd1, 5'd1, 32'd0, 1'b0), 4'd0);
        add_row(make_ins(`ALU_ADD, 5'd5, 5'd2, 5'd2, 32'd0, 1'b0), 4'd0);
        add_row(make_ins(`ALU_OR, 5'd8, 5'd5, 5'd7, 32'd0, 1'b0), 4'd0);
        add_row(make_ins(`ALU_ADD, 5'd0, 5'd1, 5'd2, 32'd0, 1'b0), 4'd0);
        add_row(make_ins(`ALU_ADD, 5'd9, 5'd0, 5'd3, 32'd0, 1'b0), 4'd0);
        // jumps and conditional branches
        add_branch(`BR_JAL, 5'd11, 5'd0, 5'd0, 32'h40);
        add_branch(`BR_JALR, 5'd12, 5'd9, 5'd0, 32'h8);
        add_branch(`BR_BEQ, 5'd0, 5'd1, 5'd1, 32'h20);
        add_branch(`BR_BEQ, 5'd0, 5'd1, 5'd2, 32'h20);
        add_branch(`BR_BNE, 5'd0, 5'd1, 5'd2, 32'hFFFF_FFF0);
        add_branch(`BR_BNE, 5'd0, 5'd3, 5'd3, 32'h10);
        // store then load two slots later, then a preloaded word
        add_mem(1'b0, 5'd5, 32'h20, 4'd0);
        add_bubble();
        add_mem(1'b1, 5'd13, 32'h20, 4'd0);
        add_mem(1'b1, 5'd14, 32'h84, 4'd0);
        add_bubble();
        add_row(make_ins(`ALU_ADD, 5'd15, 5'd14, 5'd13, 32'd0, 1'b0), 4'd0);
        // stall with a store sitting in the memory stage
        add_mem(1'b0, 5'd6, 32'h30, 4'd0);
        add_row(make_ins(`ALU_ADD, 5'd16, 5'd1, 5'd2, 32'd0, 1'b0), 4'd3);
        add_mem(1'b1, 5'd17, 32'h30, 4'd0);
        add_bubble();
        add_row(make_ins(`ALU_SUB, 5'd18, 5'd17, 5'd16, 32'd0, 1'b0), 4'd0);
    endtask

    // one clock of a row with the model pipeline advancing on non-stall edges
    task automatic run_cycle(input row_t r, input logic stall);
        @(negedge clk);
        id_ex = r.ins;
        mem_stall = stall;
        #1;
        check_val("branch_res.is_branch", 32'(branch_res.is_branch), 32'(r.br.is_branch));
        check_val("branch_res.taken", 32'(branch_res.taken), 32'(r.br.taken));
        check_val("branch_res.pc", branch_res.pc, r.br.pc);
        if (r.br.is_branch) begin
            check_val("branch_res.target", branch_res.target, r.br.target);
        end
        @(posedge clk);
        #1;
        if (!stall) begin
            wb_exp = ex_exp;
            ex_exp = r.wb;
        end
        check_val("wb.reg_write", 32'(wb.reg_write), 32'(wb_exp.reg_write));
        if (wb_exp.reg_write) begin
            check_val("wb.rd", 32'(wb.rd), 32'(wb_exp.rd));
            check_val("wb.data", wb.data, wb_exp.data);
        end
    endtask

    initial begin
        row_t idle;
        int drain;
        rst_n = 1'b0;
        mem_stall = 1'b0;
        dmem_init_en = 1'b0;
        dmem_init_addr = 6'd0;
        dmem_init_data = 32'd0;
        id_ex = '0;
        lfsr_state = 32'h6747;
        pend1 = 6'd32;
        pend2 = 6'd32;
        pc_next = 32'h0000_1000;
        ex_exp = '0;
        wb_exp = '0;
        regs_model[0] = 32'd0;
        for (int i = 1; i < 32; i++) begin
            regs_model[i] = rand32();
        end
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = fill_word(6'(i));
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            dmem_init_en = 1'b1;
            dmem_init_addr = 6'(i);
            dmem_init_data = fill_word(6'(i));
            @(posedge clk);
            #1;
            check_val("wb.reg_write", 32'(wb.reg_write), 32'd0);
        end
        @(negedge clk);
        dmem_init_en = 1'b0;
        build_table();
        foreach (rows[i]) begin
            for (int c = 0; c <= int'(rows[i].stall); c++) begin
                run_cycle(rows[i], c < int'(rows[i].stall));
            end
        end
        // drain the two slots after execute
        idle = '0;
        drain = 0;
        while (ex_exp.reg_write || wb_exp.reg_write) begin
            if (drain == 8) begin
                fail_run("pipeline did not drain within 8 cycles");
            end
            run_cycle(idle, 1'b0);
            drain++;
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== bench/exec_pipe_properties.sv ====
`timescale 1ns/100ps

module exec_pipe_properties
    import rv_exec_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        mem_stall,
    input id_ex_t      id_ex,
    input ex_mem_t     ex_mem,
    input logic [31:0] op_a,
    input logic [31:0] op_b_reg
);

    // a stalled cycle leaves the execute/memory register untouched
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_stall |=> $stable(ex_mem))
        else $error("ex_mem changed while mem_stall was high");

    // a matching execute/memory write wins for both operands
    assert property (@(posedge clk) disable iff (!rst_n)
        (ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == id_ex.rs1)
        |-> op_a == ex_mem.alu_result)
        else $error("operand a missed the ex_mem forward");

    assert property (@(posedge clk) disable iff (!rst_n)
        (ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == id_ex.rs2)
        |-> op_b_reg == ex_mem.alu_result)
        else $error("operand b missed the ex_mem forward");

endmodule

bind ex_stage exec_pipe_properties props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_stall(mem_stall),
    .id_ex    (id_ex),
    .ex_mem   (ex_mem),
    .op_a     (op_a),
    .op_b_reg (op_b_reg)
);

// ==== verilog/exec_pipe_top.sv ====
`timescale 1ns/100ps

module exec_pipe_top
    import rv_exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  id_ex_t      id_ex,
    input  logic        mem_stall,
    input  logic        dmem_init_en,
    input  logic [5:0]  dmem_init_addr,
    input  logic [31:0] dmem_init_data,
    output branch_res_t branch_res,
    output wb_t         wb
);

    ex_mem_t ex_mem;

    // wb goes out of the top and back into execute for forwarding
    ex_stage u_ex (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_stall  (mem_stall),
        .id_ex      (id_ex),
        .wb         (wb),
        .ex_mem     (ex_mem),
        .branch_res (branch_res)
    );

    mem_wb_stage u_mem_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_stall      (mem_stall),
        .ex_mem         (ex_mem),
        .dmem_init_en   (dmem_init_en),
        .dmem_init_addr (dmem_init_addr),
        .dmem_init_data (dmem_init_data),
        .wb             (wb)
    );

endmodule

// ==== verilog/mem_wb_stage.sv ====
`timescale 1ns/100ps

`include "rv_exec_consts.svh"

module mem_wb_stage
    import rv_exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_stall,
    input  ex_mem_t     ex_mem,
    input  logic        dmem_init_en,
    input  logic [5:0]  dmem_init_addr,
    input  logic [31:0] dmem_init_data,
    output wb_t         wb
);

    localparam int AW = $clog2(`DMEM_DEPTH);

    logic [31:0]   dmem [`DMEM_DEPTH];
    logic [AW-1:0] word_addr;
    logic [31:0]   load_data;
    logic          store_en;
    logic          advance;

    // word addressed, byte offset bits are dropped
    assign word_addr = ex_mem.alu_result[AW+1:2];
    assign load_data = dmem[word_addr];
    assign advance   = rst_n && !mem_stall;
    assign store_en  = advance && ex_mem.mem_write;

    // preload port only used while the pipe is idle
    always_ff @(posedge clk) begin
        if (dmem_init_en) begin
            dmem[dmem_init_addr[AW-1:0]] <= dmem_init_data;
        end else if (store_en) begin
            dmem[word_addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.reg_write <= 1'b0;
        end else if (!mem_stall) begin
            wb.reg_write <= ex_mem.reg_write;
            wb.rd        <= ex_mem.rd;
            // loads pick up the word before a same-edge store lands
            wb.data      <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        end
    end

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/100ps

`include "rv_exec_consts.svh"

module ex_stage
    import rv_exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_stall,
    input  id_ex_t      id_ex,
    input  wb_t         wb,
    output ex_mem_t     ex_mem,
    output branch_res_t branch_res
);

    logic [31:0] op_a;
    logic [31:0] op_b_reg;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] ex_result;
    logic        is_link;
    ex_mem_t     ex_mem_d;

    // forwarding sees the registered ex_mem and the writeback bundle
    forward_unit u_forward (
        .rs1      (id_ex.rs1),
        .rs2      (id_ex.rs2),
        .ex_mem   (ex_mem),
        .wb       (wb),
        .rs1_data (id_ex.rs1_data),
        .rs2_data (id_ex.rs2_data),
        .op_a     (op_a),
        .op_b     (op_b_reg)
    );

    assign op_b = id_ex.alu_src_imm ? id_ex.imm : op_b_reg;

    alu u_alu (
        .alu_op (id_ex.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_out)
    );

    branch_resolve u_branch (
        .id_ex      (id_ex),
        .op_a       (op_a),
        .alu_result (alu_out),
        .branch_res (branch_res)
    );

    // jumps write the return address instead of the alu value
    assign is_link   = id_ex.is_branch &&
                       (id_ex.br_type == `BR_JAL || id_ex.br_type == `BR_JALR);
    assign ex_result = is_link ? (id_ex.pc + `LINK_OFFSET) : alu_out;

    always_comb begin
        // an invalid bundle becomes a bubble
        ex_mem_d.reg_write  = id_ex.valid & id_ex.reg_write;
        ex_mem_d.mem_read   = id_ex.valid & id_ex.mem_read;
        ex_mem_d.mem_write  = id_ex.valid & id_ex.mem_write;
        ex_mem_d.rd         = id_ex.rd;
        ex_mem_d.alu_result = ex_result;
        ex_mem_d.store_data = op_b_reg;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else if (!mem_stall) begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

// ==== verilog/branch_resolve.sv ====
`timescale 1ns/100ps

`include "rv_exec_consts.svh"

module branch_resolve
    import rv_exec_pkg::*;
(
    input  id_ex_t      id_ex,
    input  logic [31:0] op_a,
    input  logic [31:0] alu_result,
    output branch_res_t branch_res
);

    logic [31:0] taken_target;
    logic [31:0] fall_through;
    logic        cond;
    logic        is_zero;

    assign taken_target = id_ex.pc + id_ex.imm;
    assign fall_through = id_ex.pc + 32'd4;
    // conditional branches run SUB through the alu
    assign is_zero      = (alu_result == 32'd0);

    always_comb begin
        case (id_ex.br_type)
            `BR_JAL: begin
                cond              = 1'b1;
                branch_res.target = taken_target;
            end
            `BR_JALR: begin
                cond              = 1'b1;
                branch_res.target = op_a + id_ex.imm;
            end
            `BR_BEQ: begin
                cond              = is_zero;
                branch_res.target = is_zero ? taken_target : fall_through;
            end
            default: begin
                cond              = !is_zero;
                branch_res.target = !is_zero ? taken_target : fall_through;
            end
        endcase
        branch_res.is_branch = id_ex.is_branch;
        branch_res.taken     = id_ex.is_branch & cond;
        branch_res.pc        = id_ex.pc;
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps

`include "rv_exec_consts.svh"

module alu (
    input  logic [3:0]  alu_op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    logic [4:0] shamt;

    // only the low five bits count for a 32-bit shift
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            `ALU_ADD: begin
                result = a + b;
            end
            `ALU_SUB: begin
                result = a - b;
            end
            `ALU_AND: begin
                result = a & b;
            end
            `ALU_OR: begin
                result = a | b;
            end
            `ALU_XOR: begin
                result = a ^ b;
            end
            `ALU_SLL: begin
                result = a << shamt;
            end
            `ALU_SRL: begin
                result = a >> shamt;
            end
            `ALU_SRA: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            `ALU_SLT: begin
                // signed compare
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            default: begin
                result = 32'd0;
            end
        endcase
    end

endmodule

// ==== verilog/forward_unit.sv ====
`timescale 1ns/100ps

module forward_unit
    import rv_exec_pkg::*;
(
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  ex_mem_t     ex_mem,
    input  wb_t         wb,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic [31:0] op_a,
    output logic [31:0] op_b
);

    // picks the newest pending value for one source register
    function automatic logic [31:0] resolve(
        input logic [4:0]  rs,
        input logic [31:0] reg_value,
        input ex_mem_t     em,
        input wb_t         w
    );
        logic [31:0] value;
        value = reg_value;
        // x0 always reads as the supplied zero
        if (rs != 5'd0) begin
            if (em.reg_write && em.rd == rs) begin
                value = em.alu_result;
            end else if (w.reg_write && w.rd == rs) begin
                value = w.data;
            end
        end
        return value;
    endfunction

    always_comb begin
        op_a = resolve(rs1, rs1_data, ex_mem, wb);
        op_b = resolve(rs2, rs2_data, ex_mem, wb);
    end

endmodule

// ==== verilog/rv_exec_pkg.sv ====
package rv_exec_pkg;

    // decoded bundle handed to execute, operands already read
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [3:0]  alu_op;
        logic        alu_src_imm;
        logic        is_branch;
        logic [1:0]  br_type;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
    } id_ex_t;

    // execute result as seen by the memory stage
    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic [4:0]  rd;
        logic [31:0] alu_result;
        logic [31:0] store_data;
    } ex_mem_t;

    // register file write, also the late forwarding source
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    // resolved control flow for the current execute bundle
    typedef struct packed {
        logic        is_branch;
        logic        taken;
        logic [31:0] target;
        logic [31:0] pc;
    } branch_res_t;

endpackage

// ==== verilog/rv_exec_consts.svh ====
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// alu operation codes
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR  4'd3
`define ALU_XOR 4'd4
`define ALU_SLL 4'd5
`define ALU_SRL 4'd6
`define ALU_SRA 4'd7
`define ALU_SLT 4'd8

// branch kinds, JAL and JALR share the low half of the encoding
`define BR_JAL  2'd0
`define BR_JALR 2'd1
`define BR_BEQ  2'd2
`define BR_BNE  2'd3

// data memory size in 32-bit words
`define DMEM_DEPTH 64

// return address distance from the jump pc
`define LINK_OFFSET 32'd4

`endif
